// ==== build.f ====
+incdir+tests
design/noc_topo_pkg.sv
design/noc_flit_pkg.sv
design/flit_fifo.sv
design/xy_route_select.sv
design/wormhole_arbiter.sv
design/mesh_router.sv
tests/tb_mesh_router.sv

// ==== design/flit_fifo.sv ====
// Input flit FIFO
// Circular buffer with valid/ready on both sides; the head is read from
// storage, so a flit shows up at the output one cycle after it is taken
`timescale 1ns/10ps

module flit_fifo #(
  parameter int unsigned Depth = 4
) (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  noc_flit_pkg::noc_flit_t data_i,
  input  logic                    valid_i,
  output logic                    ready_o,
  output noc_flit_pkg::noc_flit_t data_o,
  output logic                    valid_o,
  input  logic                    ready_i
);

  import noc_flit_pkg::*;

  localparam int unsigned PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntWidth = $clog2(Depth + 1);

  typedef logic [PtrWidth-1:0] ptr_t;
  typedef logic [CntWidth-1:0] cnt_t;

  noc_flit_t mem_q [Depth];

  ptr_t wr_ptr_q;
  ptr_t rd_ptr_q;
  cnt_t count_q;
  logic full;
  logic push;
  logic pop;

  function automatic ptr_t ptr_incr(ptr_t ptr);
    ptr_t nxt;
    if (ptr == ptr_t'(Depth - 1)) begin
      nxt = '0;
    end else begin
      nxt = ptr + ptr_t'(1);
    end
    return nxt;
  endfunction

  assign full    = (count_q == cnt_t'(Depth));
  // A full FIFO still takes a flit when the head leaves in the same cycle
  assign ready_o = !full || ready_i;
  assign valid_o = (count_q != '0);
  assign data_o  = mem_q[rd_ptr_q];

  assign push = valid_i && ready_o;
  assign pop  = valid_o && ready_i;

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= ptr_incr(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= ptr_incr(rd_ptr_q);
      end
      if (push && !pop) begin
        count_q <= count_q + cnt_t'(1);
      end else if (pop && !push) begin
        count_q <= count_q - cnt_t'(1);
      end
    end
  end

endmodule

// ==== design/mesh_router.sv ====
// Five-port mesh router
// XY routing with wormhole switching; each input has a flit FIFO and a
// route selector, each output a wormhole arbiter. Connections that XY
// routing never uses are removed at elaboration
`timescale 1ns/10ps

module mesh_router #(
  parameter int unsigned InFifoDepth = 4,
  parameter bit          NoLoopback  = 1'b1,
  parameter bit          XYRouteOpt  = 1'b1
) (
  input  logic                                                 clk_i,
  input  logic                                                 rst_i,
  input  noc_topo_pkg::xy_id_t                                 xy_id_i,
  // Input side
  input  noc_topo_pkg::port_mask_t                             valid_i,
  output noc_topo_pkg::port_mask_t                             ready_o,
  input  noc_flit_pkg::noc_flit_t [noc_topo_pkg::NumPorts-1:0] data_i,
  // Output side
  output noc_topo_pkg::port_mask_t                             valid_o,
  input  noc_topo_pkg::port_mask_t                             ready_i,
  output noc_flit_pkg::noc_flit_t [noc_topo_pkg::NumPorts-1:0] data_o
);

  import noc_topo_pkg::*;
  import noc_flit_pkg::*;

  // FIFO heads and their handshake
  noc_flit_t [NumPorts-1:0] in_data;
  port_mask_t               in_valid;
  port_mask_t               in_ready;

  // Indexed [input][output]
  port_mask_t [NumPorts-1:0] route_mask;
  port_mask_t [NumPorts-1:0] conn_mask;
  port_mask_t [NumPorts-1:0] in_side_ready;

  // Indexed [output][input]
  port_mask_t [NumPorts-1:0] arb_valid;
  port_mask_t [NumPorts-1:0] arb_ready;

  for (genvar in = 0; in < NumPorts; in++) begin : gen_input

    flit_fifo #(
      .Depth ( InFifoDepth )
    ) u_in_fifo (
      .clk_i   ( clk_i        ),
      .rst_i   ( rst_i        ),
      .data_i  ( data_i[in]   ),
      .valid_i ( valid_i[in]  ),
      .ready_o ( ready_o[in]  ),
      .data_o  ( in_data[in]  ),
      .valid_o ( in_valid[in] ),
      .ready_i ( in_ready[in] )
    );

    xy_route_select u_route_select (
      .xy_id_i ( xy_id_i        ),
      .flit_i  ( in_data[in]    ),
      .route_o ( route_mask[in] )
    );

    for (genvar out = 0; out < NumPorts; out++) begin : gen_conn_mask
      // Loopback, and turns from the y axis back onto the x axis,
      // never occur under XY routing
      if ((NoLoopback && (in == out)) ||
          (XYRouteOpt && ((in == North) || (in == South)) &&
           ((out == East) || (out == West)))) begin : gen_no_conn
        assign conn_mask[in][out] = 1'b0;
      end else begin : gen_conn
        assign conn_mask[in][out] = route_mask[in][out];
      end

      assign arb_valid[out][in]     = in_valid[in] && conn_mask[in][out];
      assign in_side_ready[in][out] = arb_ready[out][in];
    end

    // Only the requested output can pop the head
    assign in_ready[in] = |(in_side_ready[in] & conn_mask[in]);
  end

  for (genvar out = 0; out < NumPorts; out++) begin : gen_output

    wormhole_arbiter u_out_arb (
      .clk_i   ( clk_i          ),
      .rst_i   ( rst_i          ),
      .valid_i ( arb_valid[out] ),
      .ready_o ( arb_ready[out] ),
      .data_i  ( in_data        ),
      .valid_o ( valid_o[out]   ),
      .ready_i ( ready_i[out]   ),
      .data_o  ( data_o[out]    )
    );

  end

endmodule

// ==== design/noc_flit_pkg.sv ====
// NoC flit format
// A flit carries its destination and source position, a tail marker and
// one payload word; every flit of a packet repeats the header fields
package noc_flit_pkg;

  // Width of the payload word
  localparam int unsigned PayloadWidth = 32;

  typedef logic [PayloadWidth-1:0] payload_t;

  // Flit as it travels on every link
  // last is set on the tail flit only, a single-flit packet has it set too
  typedef struct packed {
    noc_topo_pkg::xy_id_t dst_id;
    noc_topo_pkg::xy_id_t src_id;
    logic                 last;
    payload_t             payload;
  } noc_flit_t;

endpackage

// ==== design/noc_topo_pkg.sv ====
// NoC topology definitions
// Port directions, port count and mesh coordinate types used by the router
// and by every block that indexes ports or compares positions
package noc_topo_pkg;

  // Four mesh neighbours plus the local eject port
  localparam int unsigned NumPorts = 5;

  // Bits per mesh coordinate, enough for an 8x8 mesh
  localparam int unsigned CoordWidth = 3;

  // Port directions
  // The encoding doubles as the port index on every port array
  typedef enum logic [2:0] {
    North = 3'd0,
    East  = 3'd1,
    South = 3'd2,
    West  = 3'd3,
    Eject = 3'd4
  } route_dir_e;

  // One mesh coordinate
  typedef logic [CoordWidth-1:0] coord_t;

  // Position of a router in the mesh
  // North is towards larger y, East towards larger x
  typedef struct packed {
    coord_t x;
    coord_t y;
  } xy_id_t;

  // Set of ports, one bit per route_dir_e value
  typedef logic [NumPorts-1:0] port_mask_t;

endpackage

// ==== design/wormhole_arbiter.sv ====
// Wormhole output arbiter
// Round-robin choice among requesting inputs; once committed to an input
// it stays there until the tail flit of that packet has left
`timescale 1ns/10ps

module wormhole_arbiter (
  input  logic                                                 clk_i,
  input  logic                                                 rst_i,
  input  noc_topo_pkg::port_mask_t                             valid_i,
  output noc_topo_pkg::port_mask_t                             ready_o,
  input  noc_flit_pkg::noc_flit_t [noc_topo_pkg::NumPorts-1:0] data_i,
  output logic                                                 valid_o,
  input  logic                                                 ready_i,
  output noc_flit_pkg::noc_flit_t                              data_o
);

  import noc_topo_pkg::*;
  import noc_flit_pkg::*;

  typedef enum logic {
    Idle,
    Locked
  } arb_state_e;

  arb_state_e state_q;
  route_dir_e lock_idx_q;
  route_dir_e ptr_q;
  route_dir_e rr_idx;
  route_dir_e gnt_idx;
  logic       rr_found;
  logic       gnt_valid;

  function automatic route_dir_e next_port(route_dir_e idx);
    route_dir_e nxt;
    if (idx == Eject) begin
      nxt = North;
    end else begin
      nxt = route_dir_e'(idx + 3'd1);
    end
    return nxt;
  endfunction

  // First requester at or after the pointer, wrapping around
  always_comb begin
    int unsigned cand;
    rr_found = 1'b0;
    rr_idx   = ptr_q;
    for (int unsigned k = 0; k < NumPorts; k++) begin
      cand = ptr_q + k;
      if (cand >= NumPorts) begin
        cand = cand - NumPorts;
      end
      if (!rr_found && valid_i[cand]) begin
        rr_found = 1'b1;
        rr_idx   = route_dir_e'(cand);
      end
    end
  end

  assign gnt_idx   = (state_q == Locked) ? lock_idx_q : rr_idx;
  assign gnt_valid = valid_i[gnt_idx];

  assign valid_o = gnt_valid;
  assign data_o  = data_i[gnt_idx];

  always_comb begin
    ready_o          = '0;
    ready_o[gnt_idx] = ready_i && gnt_valid;
  end

  // Lock on a non-tail transfer, and also on a stalled grant so that
  // data_o stays put while the output is back-pressured
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q    <= Idle;
      lock_idx_q <= North;
      ptr_q      <= North;
    end else if (gnt_valid) begin
      if (ready_i && data_o.last) begin
        state_q <= Idle;
        ptr_q   <= next_port(gnt_idx);
      end else begin
        state_q    <= Locked;
        lock_idx_q <= gnt_idx;
      end
    end
  end

endmodule

// ==== design/xy_route_select.sv ====
// XY route selector
// Turns the destination of a head flit into a one-hot output request,
// resolving x before y; purely combinational
`timescale 1ns/10ps

module xy_route_select (
  input  noc_topo_pkg::xy_id_t      xy_id_i,
  input  noc_flit_pkg::noc_flit_t   flit_i,
  output noc_topo_pkg::port_mask_t  route_o
);

  import noc_topo_pkg::*;
  import noc_flit_pkg::*;

  xy_id_t     dst;
  route_dir_e dir;

  assign dst = flit_i.dst_id;

  // X is settled first, y only once the column matches
  always_comb begin
    if (dst.x > xy_id_i.x) begin
      dir = East;
    end else if (dst.x < xy_id_i.x) begin
      dir = West;
    end else if (dst.y > xy_id_i.y) begin
      dir = North;
    end else if (dst.y < xy_id_i.y) begin
      dir = South;
    end else begin
      // Packet has arrived
      dir = Eject;
    end
  end

  // Exactly one bit set, since dir always holds a valid port
  assign route_o = port_mask_t'(1) << dir;

endmodule

// ==== tests/router_model.svh ====
// Router reference model
// Expected output port under XY routing, and helpers that build the
// coordinates and flits used as stimulus
`ifndef ROUTER_MODEL_SVH
`define ROUTER_MODEL_SVH

// X first, then y, eject once both match
function automatic route_dir_e expected_port(input xy_id_t own, input noc_flit_t flit);
  route_dir_e dir;
  if (flit.dst_id.x > own.x) begin
    dir = East;
  end else if (flit.dst_id.x < own.x) begin
    dir = West;
  end else if (flit.dst_id.y > own.y) begin
    dir = North;
  end else if (flit.dst_id.y < own.y) begin
    dir = South;
  end else begin
    dir = Eject;
  end
  return dir;
endfunction

function automatic xy_id_t make_id(input int x, input int y);
  xy_id_t id;
  id.x = coord_t'(x);
  id.y = coord_t'(y);
  return id;
endfunction

// Each input tags its flits with x equal to its port index
function automatic noc_flit_t make_flit(input xy_id_t dst, input int in_port,
                                        input logic last, input payload_t payload);
  noc_flit_t flit;
  flit.dst_id  = dst;
  flit.src_id  = make_id(in_port, 7);
  flit.last    = last;
  flit.payload = payload;
  return flit;
endfunction

// No loopback, and y-axis inputs stay in the own column
function automatic bit dst_allowed(input xy_id_t own, input int in_port, input xy_id_t dst);
  route_dir_e dir;
  bit         ok;
  dir = expected_port(own, make_flit(dst, in_port, 1'b1, '0));
  ok  = (int'(dir) != in_port);
  if ((in_port == int'(North) || in_port == int'(South)) && (dst.x != own.x)) begin
    ok = 1'b0;
  end
  return ok;
endfunction

`endif

// ==== tests/tb_mesh_router.sv ====
// Mesh router testbench
// Drives single flits, competing packets, back-pressure and random traffic
// into the router and checks every output flit against a reference model
`timescale 1ns/10ps

module tb_mesh_router;

  import noc_topo_pkg::*;
  import noc_flit_pkg::*;

  `include "router_model.svh"

  localparam int FifoDepth      = 4;
  localparam int RandPkts       = 10;
  localparam int TotalFlits     = NumPorts + 16 + (FifoDepth + 1) + NumPorts * RandPkts * 4;
  localparam int WatchdogCycles = TotalFlits * 40 + 2000;

  logic                     clk;
  logic                     rst;
  xy_id_t                   xy_id;
  port_mask_t               in_valid;
  port_mask_t               in_ready;
  noc_flit_t [NumPorts-1:0] in_data;
  port_mask_t               out_valid;
  port_mask_t               out_ready;
  noc_flit_t [NumPorts-1:0] out_data;

  xy_id_t own_id;
  int     seed;
  string  test_name;
  bit     traffic_on;
  int     port_errors;
  int     flit_errors;
  int     mask_errors;
  int     other_errors;

  // Expected flits per [input][output]
  noc_flit_t exp_q [NumPorts][NumPorts][$];
  bit        pkt_open [NumPorts];
  int        pkt_owner [NumPorts];

  mesh_router #(
    .InFifoDepth ( FifoDepth )
  ) u_dut (
    .clk_i   ( clk       ),
    .rst_i   ( rst       ),
    .xy_id_i ( xy_id     ),
    .valid_i ( in_valid  ),
    .ready_o ( in_ready  ),
    .data_i  ( in_data   ),
    .valid_o ( out_valid ),
    .ready_i ( out_ready ),
    .data_o  ( out_data  )
  );

  always #5 clk = ~clk;

  task automatic check_port(input string name, input route_dir_e exp, input route_dir_e act);
    if (exp !== act) begin
      port_errors++;
      $display("error %s: expected port %s, actual port %s", name, exp.name(), act.name());
    end
  endtask

  task automatic check_flit(input string name, input noc_flit_t exp, input noc_flit_t act);
    if (exp !== act) begin
      flit_errors++;
      $display("error %s: expected flit %h, actual flit %h", name, exp, act);
    end
  endtask

  task automatic check_mask(input string name, input port_mask_t exp, input port_mask_t act);
    if (exp !== act) begin
      mask_errors++;
      $display("error %s: expected mask %b, actual mask %b", name, exp, act);
    end
  endtask

  function automatic int pending_flits();
    int n;
    n = 0;
    for (int i = 0; i < NumPorts; i++) begin
      for (int o = 0; o < NumPorts; o++) begin
        n += exp_q[i][o].size();
      end
    end
    return n;
  endfunction

  task automatic push_expected(input int in_port, input noc_flit_t flit);
    exp_q[in_port][int'(expected_port(own_id, flit))].push_back(flit);
  endtask

  // Offers one flit, starting and ending on a falling edge
  task automatic send_flit(input int in_port, input noc_flit_t flit);
    push_expected(in_port, flit);
    in_data[in_port]  = flit;
    in_valid[in_port] = 1'b1;
    @(posedge clk);
    while (!in_ready[in_port]) begin
      @(posedge clk);
    end
    @(negedge clk);
    in_valid[in_port] = 1'b0;
  endtask

  task automatic send_packet(input int in_port, input xy_id_t dst, input int len);
    noc_flit_t flit;
    for (int k = 0; k < len; k++) begin
      flit = make_flit(dst, in_port, k == len - 1, payload_t'($random(seed)));
      send_flit(in_port, flit);
    end
  endtask

  task automatic wait_drain();
    while (pending_flits() != 0) begin
      @(negedge clk);
    end
    repeat (2) @(negedge clk);
  endtask

  task automatic pick_dst(input int in_port, output xy_id_t dst);
    dst = make_id($random(seed), $random(seed));
    while (!dst_allowed(own_id, in_port, dst)) begin
      dst = make_id($random(seed), $random(seed));
    end
  endtask

  task automatic run_reset_check();
    test_name = "reset";
    check_mask(test_name, '0, out_valid);
    check_mask(test_name, '1, in_ready);
  endtask

  // One tail flit per input, seen on its output one cycle after acceptance
  task automatic run_single();
    xy_id_t     dst [NumPorts];
    noc_flit_t  flit;
    route_dir_e exp_dir;
    test_name    = "single_flit";
    dst[North]   = make_id(3, 1);
    dst[East]    = make_id(1, 3);
    dst[South]   = make_id(3, 5);
    dst[West]    = make_id(3, 3);
    dst[Eject]   = make_id(6, 2);
    for (int i = 0; i < NumPorts; i++) begin
      flit    = make_flit(dst[i], i, 1'b1, payload_t'($random(seed)));
      exp_dir = expected_port(own_id, flit);
      send_flit(i, flit);
      check_mask(test_name, port_mask_t'(1) << exp_dir, out_valid);
      wait_drain();
    end
  endtask

  // Two packets compete for Eject, then two for South
  task automatic run_wormhole();
    test_name = "wormhole";
    fork
      send_packet(East, make_id(3, 3), 4);
      send_packet(West, make_id(3, 3), 4);
    join
    wait_drain();
    fork
      send_packet(North, make_id(3, 1), 4);
      send_packet(Eject, make_id(3, 0), 4);
    join
    wait_drain();
  endtask

  task automatic run_backpressure();
    xy_id_t    dst;
    noc_flit_t flit;
    int        out_port;
    int        loaded;
    int        accepted;
    test_name = "backpressure";
    dst       = make_id(5, 3);
    out_port  = int'(expected_port(own_id, make_flit(dst, Eject, 1'b1, '0)));
    out_ready[out_port] = 1'b0;
    loaded   = 0;
    accepted = 0;
    repeat (FifoDepth + 4) begin
      if (accepted == loaded && loaded <= FifoDepth) begin
        flit = make_flit(dst, Eject, loaded == FifoDepth, payload_t'(32'h4000 + loaded));
        push_expected(Eject, flit);
        in_data[Eject]  = flit;
        in_valid[Eject] = 1'b1;
        loaded++;
      end else if (accepted == loaded) begin
        in_valid[Eject] = 1'b0;
      end
      @(posedge clk);
      if (in_valid[Eject] && in_ready[Eject]) begin
        accepted++;
      end
      @(negedge clk);
    end
    if (accepted != FifoDepth) begin
      other_errors++;
      $display("error %s: expected %0d flits accepted, actual %0d",
               test_name, FifoDepth, accepted);
    end
    out_ready[out_port] = 1'b1;
    if (accepted < loaded) begin
      @(posedge clk);
      while (!in_ready[Eject]) begin
        @(posedge clk);
      end
      @(negedge clk);
    end
    in_valid[Eject] = 1'b0;
    wait_drain();
  endtask

  task automatic send_random(input int in_port);
    xy_id_t dst;
    int     len;
    int     gap;
    for (int p = 0; p < RandPkts; p++) begin
      pick_dst(in_port, dst);
      len = 1 + ($unsigned($random(seed)) % 4);
      send_packet(in_port, dst, len);
      gap = $unsigned($random(seed)) % 3;
      repeat (gap) @(negedge clk);
    end
  endtask

  // Each output is ready about three cycles in four
  task automatic stall_outputs();
    while (traffic_on) begin
      @(negedge clk);
      for (int o = 0; o < NumPorts; o++) begin
        out_ready[o] = (($random(seed) & 3) != 0);
      end
    end
    out_ready = '1;
  endtask

  task automatic run_random();
    test_name  = "random";
    traffic_on = 1'b1;
    fork
      stall_outputs();
      begin
        fork
          send_random(North);
          send_random(East);
          send_random(South);
          send_random(West);
          send_random(Eject);
        join
        traffic_on = 1'b0;
      end
    join
    wait_drain();
  endtask

  // Output monitor and scoreboard
  always @(posedge clk) begin : monitor
    int        src_in;
    noc_flit_t flit;
    if (!rst) begin
      for (int o = 0; o < NumPorts; o++) begin
        if (out_valid[o] && out_ready[o]) begin
          flit   = out_data[o];
          src_in = int'(flit.src_id.x);
          check_port(test_name, expected_port(own_id, flit), route_dir_e'(o));
          if (src_in >= NumPorts) begin
            other_errors++;
            $display("Output %0d carried a flit with unknown source %0d", o, src_in);
          end else if (exp_q[src_in][o].size() == 0) begin
            other_errors++;
            $display("Output %0d carried an unexpected flit %h", o, flit);
          end else begin
            check_flit(test_name, exp_q[src_in][o].pop_front(), flit);
          end
          // A packet must leave as one unbroken run of flits
          if (pkt_open[o] && pkt_owner[o] != src_in) begin
            other_errors++;
            $display("Output %0d mixed a flit from input %0d into a packet from input %0d",
                     o, src_in, pkt_owner[o]);
          end
          pkt_open[o]  = !flit.last;
          pkt_owner[o] = src_in;
        end
      end
    end
  end

  initial begin : watchdog
    repeat (WatchdogCycles) @(posedge clk);
    $display("Run did not finish within %0d cycles, flits stopped moving", WatchdogCycles);
    $display("STATUS: FAIL");
    $finish;
  end

  initial begin : main
    clk          = 1'b0;
    rst          = 1'b1;
    seed         = 32'h034f_9b19;
    own_id       = make_id(3, 3);
    xy_id        = own_id;
    in_valid     = '0;
    in_data      = '0;
    out_ready    = '1;
    traffic_on   = 1'b0;
    test_name    = "init";
    port_errors  = 0;
    flit_errors  = 0;
    mask_errors  = 0;
    other_errors = 0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    run_reset_check();
    run_single();
    run_wormhole();
    run_backpressure();
    run_random();
    $display("errors: port %0d, flit %0d, mask %0d, other %0d",
             port_errors, flit_errors, mask_errors, other_errors);
    if (port_errors + flit_errors + mask_errors + other_errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule
